// File: tb_tlb_l2.sv
//////////////////////////////////////////////////
// Directed testbench for the L2 TLB
// Reference model, compare tasks and watchdog
//////////////////////////////////////////////////

`include "tlb_l2_consts.svh"

module tb_tlb_l2;
   timeunit 1ns;
   timeprecision 1ps;

   import tlb_l2_pkg::*;

   typedef enum {RES_NONE, RES_HIT, RES_MISS, RES_PROT, RES_MULTI} result_e;

   localparam int          CLK_PERIOD  = 40;
   localparam int          INIT_CYCLES = 2 ** `TLB_CFG_ADDR_WIDTH;   // One write per word
   localparam int          TEST_CYCLES = 6 * 40 * 20;
   localparam int          WATCHDOG_NS = (INIT_CYCLES + TEST_CYCLES) * CLK_PERIOD;
   localparam logic [31:0] SEED        = 32'hdc173f35;

   logic        clk, rst_n, req, trans_sent, cfg_we;
   va_addr_t    req_addr;
   access_e     req_acc;
   cfg_addr_t   cfg_addr;
   logic [31:0] cfg_wdata;
   logic        busy, hit, miss, prot, multi_hit, coherent;
   pa_addr_t    out_addr;

   // Both models are indexed by configuration address bits 9..0
   va_word_t    va_model [2 ** `TLB_CFG_PA_SEL_BIT];
   ppn_word_t   pa_model [2 ** `TLB_CFG_PA_SEL_BIT];
   int          errors;
   int          checks;
   logic        bg_stop;

   tlb_l2 uut (
      .clk_i        (clk),
      .rst_ni       (rst_n),
      .req_i        (req),
      .req_addr_i   (req_addr),
      .req_acc_i    (req_acc),
      .trans_sent_i (trans_sent),
      .cfg_we_i     (cfg_we),
      .cfg_addr_i   (cfg_addr),
      .cfg_wdata_i  (cfg_wdata),
      .busy_o       (busy),
      .hit_o        (hit),
      .miss_o       (miss),
      .prot_o       (prot),
      .multi_hit_o  (multi_hit),
      .coherent_o   (coherent),
      .out_addr_o   (out_addr)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("Timeout: run exceeded %0d ns without finishing", WATCHDOG_NS);
      $display("Verification failed");
      $finish;
   end

   //////////////////////////////////////////////////
   // Compare tasks
   //////////////////////////////////////////////////

   task automatic check_kind(string name, result_e exp, result_e act);
      checks++;
      if (exp != act) begin
         errors++;
         $display("FAIL %s: expected %s, actual %s", name, exp.name(), act.name());
      end
   endtask

   task automatic check_addr(string name, pa_addr_t exp, pa_addr_t act);
      checks++;
      if (exp !== act) begin
         errors++;
         $display("FAIL %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic check_flag(string name, logic exp, logic act);
      checks++;
      if (exp !== act) begin
         errors++;
         $display("FAIL %s: expected %b, actual %b", name, exp, act);
      end
   endtask

   //////////////////////////////////////////////////
   // Reference model
   //////////////////////////////////////////////////

   function automatic result_e predict(vpn_t vpn, access_e acc,
                                       logic [`TLB_PAGE_BITS-1:0] pofs,
                                       output pa_addr_t addr, output logic coh);
      int       n_banks;
      int       n_halves;
      logic     dual;
      pa_idx_t  idx;
      pa_idx_t  hit_idx;
      va_word_t word;
      addr    = '0;
      coh     = 1'b0;
      hit_idx = '0;
      for (int off = 0; off < 2 ** `TLB_OFFSET_BITS; off++) begin
         n_banks = 0;
         dual    = 1'b0;
         for (int b = 0; b < `TLB_NUM_BANKS; b++) begin
            n_halves = 0;
            for (int h = 0; h < 2; h++) begin
               idx  = {set_idx_t'(vpn), offset_idx_t'(off), 1'(h), bank_idx_t'(b)};
               word = va_model[idx];
               if (word[`TLB_VA_VALID_BIT] && vpn_t'(word) == vpn) begin
                  n_halves++;
                  hit_idx = idx;
               end
            end
            if (n_halves == 2) dual = 1'b1;
            if (n_halves > 0)  n_banks++;
         end
         if (dual || n_banks > 1) return RES_MULTI;
         if (n_banks == 1) begin   // First matching offset decides
            word = va_model[hit_idx];
            if (!word[(acc == ACC_WRITE) ? `TLB_VA_WR_BIT : `TLB_VA_RD_BIT]) return RES_PROT;
            addr = {pa_model[hit_idx], pofs};
            coh  = word[`TLB_VA_COH_BIT];
            return RES_HIT;
         end
      end
      return RES_MISS;
   endfunction

   function automatic vpn_t rand_vpn(set_idx_t set);
      return vpn_t'({$urandom, set});
   endfunction

   //////////////////////////////////////////////////
   // Drivers
   //////////////////////////////////////////////////

   task automatic write_word(cfg_addr_t addr, logic [31:0] data);
      @(posedge clk);
      cfg_we    <= 1'b1;
      cfg_addr  <= addr;
      cfg_wdata <= data;
      if (addr[`TLB_CFG_PA_SEL_BIT]) pa_model[pa_idx_t'(addr)] = ppn_word_t'(data);
      else                           va_model[pa_idx_t'(addr)] = va_word_t'(data);
   endtask

   task automatic release_cfg();
      @(posedge clk);
      cfg_we <= 1'b0;
   endtask

   task automatic place_entry(set_idx_t set, offset_idx_t off, logic half, bank_idx_t bank,
                              vpn_t vpn, logic rd, logic wr, logic coh, ppn_word_t ppn);
      pa_idx_t idx;
      idx = {set, off, half, bank};
      write_word({1'b0, idx}, 32'({coh, wr, rd, 1'b1, vpn}));
      write_word({1'b1, idx}, 32'(ppn));
      release_cfg();
   endtask

   // Invalid entries, the other bits follow the address
   task automatic clear_tables();
      logic [31:0] fill;
      for (int a = 0; a < INIT_CYCLES; a++) begin
         fill = ((32'(a) << 13) ^ 32'(a)) & ~(32'h1 << `TLB_VA_VALID_BIT);
         write_word(cfg_addr_t'(a), fill);
      end
      release_cfg();
   endtask

   task automatic run_req(string name, va_addr_t addr, access_e acc);
      result_e  exp_kind;
      result_e  act_kind;
      pa_addr_t exp_addr;
      logic     exp_coh;
      int       cycles;
      exp_kind = predict(vpn_t'(addr >> `TLB_PAGE_BITS), acc, addr[`TLB_PAGE_BITS-1:0],
                         exp_addr, exp_coh);
      @(negedge clk);
      while (busy) @(negedge clk);
      @(posedge clk);
      req      <= 1'b1;
      req_addr <= addr;
      req_acc  <= acc;
      @(posedge clk);
      req <= 1'b0;
      act_kind = RES_NONE;
      cycles   = 0;
      while (act_kind == RES_NONE && cycles < 200) begin
         @(negedge clk);
         cycles++;
         if (hit)            act_kind = RES_HIT;
         else if (miss)      act_kind = RES_MISS;
         else if (prot)      act_kind = RES_PROT;
         else if (multi_hit) act_kind = RES_MULTI;
      end
      if (act_kind == RES_NONE) begin
         errors++;
         $display("No result pulse for %s within %0d cycles", name, cycles);
      end else begin
         check_kind(name, exp_kind, act_kind);
         if (act_kind == RES_HIT) begin
            if (exp_kind == RES_HIT) begin
               check_addr(name, exp_addr, out_addr);
               check_flag({name, " coherent"}, exp_coh, coherent);
            end
            repeat (2) begin
               @(negedge clk);
               check_flag({name, " busy before trans_sent"}, 1'b1, busy);
            end
            @(posedge clk);
            trans_sent <= 1'b1;
            @(posedge clk);
            trans_sent <= 1'b0;
            @(negedge clk);
            if (exp_kind == RES_HIT) check_addr({name, " held"}, exp_addr, out_addr);
         end else begin
            @(negedge clk);   // Non-hit results free the unit on their own
         end
         check_flag({name, " busy released"}, 1'b0, busy);
      end
   endtask

   //////////////////////////////////////////////////
   // Tests
   //////////////////////////////////////////////////

   task automatic test_reset_state();
      @(negedge clk);
      check_flag("reset busy", 1'b0, busy);
      check_flag("reset hit", 1'b0, hit);
      check_flag("reset miss", 1'b0, miss);
      check_flag("reset prot", 1'b0, prot);
      check_flag("reset multi_hit", 1'b0, multi_hit);
      check_flag("reset coherent", 1'b0, coherent);
      check_addr("reset out_addr", '0, out_addr);
   endtask

   task automatic test_read_hit();
      vpn_t vpn;
      for (int i = 0; i < 4; i++) begin   // Every offset, bank and half once
         vpn = rand_vpn(set_idx_t'(i + 1));
         place_entry(set_idx_t'(i + 1), offset_idx_t'(3 - i), i[0], bank_idx_t'(i), vpn,
                     1'b1, 1'b0, i[0], ppn_word_t'($urandom));
         run_req("read_hit", {vpn, 12'($urandom)}, ACC_READ);
      end
   endtask

   task automatic test_miss();
      vpn_t vpn;
      vpn = rand_vpn(5'd7);
      place_entry(5'd8, 2'd0, 1'b0, 2'd1, vpn, 1'b1, 1'b1, 1'b0, ppn_word_t'($urandom));
      run_req("miss_other_set", {vpn, 12'($urandom)}, ACC_READ);
      run_req("miss_absent", {rand_vpn(5'd9), 12'($urandom)}, ACC_WRITE);
   endtask

   task automatic test_protection();
      vpn_t ro_vpn;
      vpn_t wo_vpn;
      ro_vpn = rand_vpn(5'd10);
      wo_vpn = rand_vpn(5'd11);
      place_entry(5'd10, 2'd1, 1'b0, 2'd3, ro_vpn, 1'b1, 1'b0, 1'b1, ppn_word_t'($urandom));
      place_entry(5'd11, 2'd2, 1'b1, 2'd0, wo_vpn, 1'b0, 1'b1, 1'b0, ppn_word_t'($urandom));
      run_req("prot_write_to_ro", {ro_vpn, 12'($urandom)}, ACC_WRITE);
      run_req("read_of_ro", {ro_vpn, 12'($urandom)}, ACC_READ);
      run_req("prot_read_of_wo", {wo_vpn, 12'($urandom)}, ACC_READ);
      run_req("write_to_wo", {wo_vpn, 12'($urandom)}, ACC_WRITE);
   endtask

   task automatic test_multi_hit();
      vpn_t vpn;
      vpn = rand_vpn(5'd12);   // Two banks, same offset
      place_entry(5'd12, 2'd1, 1'b0, 2'd0, vpn, 1'b1, 1'b1, 1'b0, ppn_word_t'($urandom));
      place_entry(5'd12, 2'd1, 1'b1, 2'd3, vpn, 1'b1, 1'b1, 1'b0, ppn_word_t'($urandom));
      run_req("multi_two_banks", {vpn, 12'($urandom)}, ACC_READ);
      vpn = rand_vpn(5'd13);   // Both halves of one bank
      place_entry(5'd13, 2'd0, 1'b0, 2'd1, vpn, 1'b1, 1'b1, 1'b1, ppn_word_t'($urandom));
      place_entry(5'd13, 2'd0, 1'b1, 2'd1, vpn, 1'b1, 1'b1, 1'b1, ppn_word_t'($urandom));
      run_req("multi_two_halves", {vpn, 12'($urandom)}, ACC_WRITE);
      vpn = rand_vpn(5'd14);   // Different offsets, the earlier one wins
      place_entry(5'd14, 2'd3, 1'b0, 2'd0, vpn, 1'b1, 1'b1, 1'b0, ppn_word_t'($urandom));
      place_entry(5'd14, 2'd1, 1'b1, 2'd2, vpn, 1'b1, 1'b1, 1'b1, ppn_word_t'($urandom));
      run_req("first_offset_wins", {vpn, 12'($urandom)}, ACC_READ);
   endtask

   // Background writes stay in set 31, which no search uses
   task automatic test_writes_during_search();
      vpn_t vpns [$];
      vpn_t vpn;
      for (int i = 0; i < 40; i++) begin
         vpn = rand_vpn(set_idx_t'($urandom_range(30)));
         vpns.push_back(vpn);
         if ($urandom_range(3) != 0) begin
            place_entry(set_idx_t'(vpn), offset_idx_t'($urandom), 1'($urandom),
                        bank_idx_t'($urandom), vpn, 1'($urandom), 1'($urandom),
                        1'($urandom), ppn_word_t'($urandom));
         end
      end
      bg_stop = 1'b0;
      fork
         begin
            foreach (vpns[i]) begin
               run_req("random_search", {vpns[i], 12'($urandom)}, access_e'($urandom_range(1)));
            end
            bg_stop = 1'b1;
         end
         begin
            while (!bg_stop) begin
               write_word({1'($urandom), 5'd31, 5'($urandom)}, $urandom);
               release_cfg();
            end
         end
      join
   endtask

   initial begin
      void'($urandom(SEED));
      errors     = 0;
      checks     = 0;
      bg_stop    = 1'b0;
      rst_n      = 1'b0;
      req        = 1'b0;
      req_addr   = '0;
      req_acc    = ACC_READ;
      trans_sent = 1'b0;
      cfg_we     = 1'b0;
      cfg_addr   = '0;
      cfg_wdata  = '0;
      repeat (4) @(posedge clk);
      rst_n <= 1'b1;
      test_reset_state();
      clear_tables();
      test_read_hit();
      test_miss();
      test_protection();
      test_multi_hit();
      test_writes_during_search();
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

// File: tlb_l2.f
+incdir+.
tlb_l2_pkg.sv
tlb_l2_ram.sv
tlb_l2_va_bank.sv
tlb_l2_search_ctrl.sv
tlb_l2_result.sv
tlb_l2.sv
tb_tlb_l2.sv

// File: tlb_l2.sv
//////////////////////////////////////////////////
// Second-level IOMMU TLB top level
// Search controller, four banks, result stage
//////////////////////////////////////////////////

`include "tlb_l2_consts.svh"

module tlb_l2 (
   input  logic                  clk_i,
   input  logic                  rst_ni,
   input  logic                  req_i,
   input  tlb_l2_pkg::va_addr_t  req_addr_i,
   input  tlb_l2_pkg::access_e   req_acc_i,
   input  logic                  trans_sent_i,
   input  logic                  cfg_we_i,
   input  tlb_l2_pkg::cfg_addr_t cfg_addr_i,
   input  logic [31:0]           cfg_wdata_i,
   output logic                  busy_o,
   output logic                  hit_o,
   output logic                  miss_o,
   output logic                  prot_o,
   output logic                  multi_hit_o,
   output logic                  coherent_o,
   output tlb_l2_pkg::pa_addr_t  out_addr_o
);

   import tlb_l2_pkg::*;

   logic                                          lookup, last, found, result_done;
   set_idx_t                                      srch_set;
   offset_idx_t                                   srch_offset;
   vpn_t                                          srch_vpn;
   access_e                                       srch_acc;
   logic [`TLB_PAGE_BITS-1:0]                     page_offset;
   logic [`TLB_NUM_BANKS-1:0]                     match, dual_match, perm_fault, coherent;
   logic [`TLB_NUM_BANKS-1:0][$bits(entry_idx_t):0] hit_entry;

   tlb_l2_search_ctrl u_search_ctrl (
      .clk_i         (clk_i),
      .rst_ni        (rst_ni),
      .req_i         (req_i),
      .req_addr_i    (req_addr_i),
      .req_acc_i     (req_acc_i),
      .cfg_we_i      (cfg_we_i),
      .found_i       (found),
      .result_done_i (result_done),
      .trans_sent_i  (trans_sent_i),
      .busy_o        (busy_o),
      .lookup_o      (lookup),
      .set_o         (srch_set),
      .offset_o      (srch_offset),
      .vpn_o         (srch_vpn),
      .acc_o         (srch_acc),
      .last_o        (last),
      .page_offset_o (page_offset)
   );

   for (genvar b = 0; b < `TLB_NUM_BANKS; b++) begin : g_bank
      tlb_l2_va_bank #(
         .BANK_ID (b)
      ) u_bank (
         .clk_i        (clk_i),
         .rst_ni       (rst_ni),
         .cfg_we_i     (cfg_we_i),
         .cfg_addr_i   (cfg_addr_i),
         .cfg_wdata_i  (cfg_wdata_i[`TLB_VA_DATA_WIDTH-1:0]),
         .lookup_i     (lookup),
         .set_i        (srch_set),
         .offset_i     (srch_offset),
         .vpn_i        (srch_vpn),
         .acc_i        (srch_acc),
         .match_o      (match[b]),
         .dual_match_o (dual_match[b]),
         .perm_fault_o (perm_fault[b]),
         .coherent_o   (coherent[b]),
         .hit_entry_o  (hit_entry[b])
      );
   end

   tlb_l2_result u_result (
      .clk_i         (clk_i),
      .rst_ni        (rst_ni),
      .match_i       (match),
      .dual_match_i  (dual_match),
      .perm_fault_i  (perm_fault),
      .coherent_i    (coherent),
      .hit_entry_i   (hit_entry),
      .last_i        (last),
      .page_offset_i (page_offset),
      .cfg_we_i      (cfg_we_i),
      .cfg_addr_i    (cfg_addr_i),
      .cfg_wdata_i   (cfg_wdata_i[`TLB_PA_DATA_WIDTH-1:0]),
      .found_o       (found),
      .result_done_o (result_done),
      .hit_o         (hit_o),
      .miss_o        (miss_o),
      .prot_o        (prot_o),
      .multi_hit_o   (multi_hit_o),
      .coherent_o    (coherent_o),
      .out_addr_o    (out_addr_o)
   );

endmodule

// File: tlb_l2_consts.svh
//////////////////////////////////////////////////
// Address widths, page size and table geometry
// Configuration address fields
// Virtual entry word bit positions
//////////////////////////////////////////////////

`ifndef TLB_L2_CONSTS_SVH
`define TLB_L2_CONSTS_SVH

`define TLB_VA_WIDTH        32
`define TLB_PA_WIDTH        40
`define TLB_PAGE_BITS       12  // 4 kB pages

// Table geometry
`define TLB_SET_BITS        5
`define TLB_OFFSET_BITS     2
`define TLB_NUM_BANKS       4
`define TLB_BANK_BITS       2

// Configuration word address
`define TLB_CFG_ADDR_WIDTH  11
`define TLB_CFG_PA_SEL_BIT  10  // High selects the physical-page RAM
`define TLB_CFG_HALF_BIT    2
`define TLB_CFG_OFFSET_LSB  3   // Entry index starts here

// RAM word widths
`define TLB_VA_DATA_WIDTH   24
`define TLB_PA_DATA_WIDTH   28

// Virtual entry word, page number in the low bits
`define TLB_VA_VALID_BIT    20
`define TLB_VA_RD_BIT       21
`define TLB_VA_WR_BIT       22
`define TLB_VA_COH_BIT      23

`endif

// File: tlb_l2_pkg.sv
//////////////////////////////////////////////////
// Address, page number and index types
// Access type and FSM state enums
//////////////////////////////////////////////////

`include "tlb_l2_consts.svh"

package tlb_l2_pkg;

   // Addresses and page numbers
   typedef logic [`TLB_VA_WIDTH-1:0]                 va_addr_t;
   typedef logic [`TLB_PA_WIDTH-1:0]                 pa_addr_t;
   typedef logic [`TLB_VA_WIDTH-`TLB_PAGE_BITS-1:0]  vpn_t;
   typedef logic [`TLB_PA_WIDTH-`TLB_PAGE_BITS-1:0]  ppn_t;

   // Table indices
   typedef logic [`TLB_SET_BITS-1:0]                     set_idx_t;
   typedef logic [`TLB_OFFSET_BITS-1:0]                  offset_idx_t;
   typedef logic [`TLB_SET_BITS+`TLB_OFFSET_BITS-1:0]    entry_idx_t;  // Set, then offset
   typedef logic [`TLB_BANK_BITS-1:0]                    bank_idx_t;
   typedef logic [`TLB_CFG_PA_SEL_BIT-1:0]               pa_idx_t;

   // Configuration port
   typedef logic [`TLB_CFG_ADDR_WIDTH-1:0]  cfg_addr_t;
   typedef logic [`TLB_VA_DATA_WIDTH-1:0]   va_word_t;
   typedef logic [`TLB_PA_DATA_WIDTH-1:0]   ppn_word_t;

   typedef enum logic {
      ACC_READ,
      ACC_WRITE
   } access_e;

   typedef enum logic [1:0] {
      S_IDLE,
      S_START,
      S_SEARCH,
      S_DONE
   } search_state_e;

   typedef enum logic [1:0] {
      O_IDLE,
      O_WAIT_WRITE,
      O_SEND
   } out_state_e;

endpackage

// File: tlb_l2_ram.sv
//////////////////////////////////////////////////
// Single-port synchronous RAM
// Write wins over read, read data one cycle later
//////////////////////////////////////////////////

module tlb_l2_ram #(
   parameter int unsigned ADDR_WIDTH = 7,
   parameter int unsigned DATA_WIDTH = 24
) (
   input  logic                  clk_i,
   input  logic                  we_i,
   input  logic [ADDR_WIDTH-1:0] addr_i,
   input  logic [DATA_WIDTH-1:0] wdata_i,
   output logic [DATA_WIDTH-1:0] rdata_o
);

   localparam int unsigned DEPTH = 2 ** ADDR_WIDTH;

   logic [DATA_WIDTH-1:0] mem [DEPTH];

   always_ff @(posedge clk_i) begin
      if (we_i) begin
         mem[addr_i] <= wdata_i;
      end
      rdata_o <= mem[addr_i];   // Address is shared, a write cycle reads its own slot
   end

endmodule

// File: tlb_l2_result.sv
//////////////////////////////////////////////////
// Hit resolution across the banks
// Output FSM and physical-page RAM
// Result pulses and held output address
//////////////////////////////////////////////////

`include "tlb_l2_consts.svh"

module tlb_l2_result (
   input  logic                                                        clk_i,
   input  logic                                                        rst_ni,
   input  logic [`TLB_NUM_BANKS-1:0]                                   match_i,
   input  logic [`TLB_NUM_BANKS-1:0]                                   dual_match_i,
   input  logic [`TLB_NUM_BANKS-1:0]                                   perm_fault_i,
   input  logic [`TLB_NUM_BANKS-1:0]                                   coherent_i,
   input  logic [`TLB_NUM_BANKS-1:0][$bits(tlb_l2_pkg::entry_idx_t):0] hit_entry_i,
   input  logic                                                        last_i,
   input  logic [`TLB_PAGE_BITS-1:0]                                   page_offset_i,
   input  logic                                                        cfg_we_i,
   input  tlb_l2_pkg::cfg_addr_t                                       cfg_addr_i,
   input  tlb_l2_pkg::ppn_word_t                                       cfg_wdata_i,
   output logic                                                        found_o,
   output logic                                                        result_done_o,
   output logic                                                        hit_o,
   output logic                                                        miss_o,
   output logic                                                        prot_o,
   output logic                                                        multi_hit_o,
   output logic                                                        coherent_o,
   output tlb_l2_pkg::pa_addr_t                                        out_addr_o
);

   import tlb_l2_pkg::*;

   out_state_e  out_q, out_d;
   logic        last_q;           // Aligned with the bank flags
   logic        any_match, multi, prot_res;
   bank_idx_t   sel;
   pa_idx_t     res_idx, idx_q, rd_idx, pa_addr;
   logic        coh_q, coh_sel;
   logic        pa_we;
   ppn_t        pa_rdata;
   pa_addr_t    hit_addr, addr_q;
   logic        hit_d, miss_d, prot_d, multi_d;

   //////////////////////////////////////////////////
   // Resolution
   //////////////////////////////////////////////////

   always_comb begin
      any_match = 1'b0;
      multi     = |dual_match_i;   // Both halves of one bank
      sel       = '0;
      for (int b = 0; b < `TLB_NUM_BANKS; b++) begin
         if (match_i[b]) begin
            if (any_match) multi = 1'b1;
            else           sel   = bank_idx_t'(b);
            any_match = 1'b1;
         end
      end
   end

   assign prot_res = !multi && perm_fault_i[sel];
   assign res_idx  = {hit_entry_i[sel], sel};
   assign found_o  = (out_q == O_IDLE) && any_match;

   //////////////////////////////////////////////////
   // Output FSM
   //////////////////////////////////////////////////

   assign pa_we = cfg_we_i && cfg_addr_i[`TLB_CFG_PA_SEL_BIT];

   always_comb begin
      out_d   = out_q;
      hit_d   = 1'b0;
      miss_d  = 1'b0;
      prot_d  = 1'b0;
      multi_d = 1'b0;
      unique case (out_q)
         O_IDLE: begin
            // Flags arriving outside idle belong to a discarded read
            if (any_match || last_q) begin
               out_d = O_SEND;
               if (multi)           multi_d = 1'b1;
               else if (prot_res)   prot_d  = 1'b1;
               else if (!any_match) miss_d  = 1'b1;
               else if (pa_we)      out_d   = O_WAIT_WRITE;
               else                 hit_d   = 1'b1;
            end
         end
         O_WAIT_WRITE: begin
            if (!pa_we) begin
               out_d = O_SEND;
               hit_d = 1'b1;
            end
         end
         O_SEND:  out_d = O_IDLE;
         default: out_d = O_IDLE;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         out_q       <= O_IDLE;
         last_q      <= 1'b0;
         hit_o       <= 1'b0;
         miss_o      <= 1'b0;
         prot_o      <= 1'b0;
         multi_hit_o <= 1'b0;
         coherent_o  <= 1'b0;
         addr_q      <= '0;
      end else begin
         out_q       <= out_d;
         last_q      <= last_i;
         hit_o       <= hit_d;
         miss_o      <= miss_d;
         prot_o      <= prot_d;
         multi_hit_o <= multi_d;
         if (hit_d) coherent_o <= coh_sel;
         if (hit_o) addr_q     <= hit_addr;
      end
   end

   // Hit held while waiting for the physical write
   always_ff @(posedge clk_i) begin
      if (out_q == O_IDLE) begin
         idx_q <= res_idx;
         coh_q <= coherent_i[sel];
      end
   end

   assign coh_sel = (out_q == O_WAIT_WRITE) ? coh_q : coherent_i[sel];

   //////////////////////////////////////////////////
   // Physical-page RAM
   //////////////////////////////////////////////////

   assign rd_idx  = (out_q == O_WAIT_WRITE) ? idx_q : res_idx;
   assign pa_addr = pa_we ? cfg_addr_i[`TLB_CFG_PA_SEL_BIT-1:0] : rd_idx;

   tlb_l2_ram #(
      .ADDR_WIDTH ($bits(pa_idx_t)),
      .DATA_WIDTH (`TLB_PA_DATA_WIDTH)
   ) u_pa_ram (
      .clk_i   (clk_i),
      .we_i    (pa_we),
      .addr_i  (pa_addr),
      .wdata_i (cfg_wdata_i),
      .rdata_o (pa_rdata)
   );

   assign hit_addr      = {pa_rdata, page_offset_i};
   assign out_addr_o    = hit_o ? hit_addr : addr_q;   // RAM data is only valid in the pulse cycle
   assign result_done_o = miss_o || prot_o || multi_hit_o;

   a_one_result : assert property (@(posedge clk_i) disable iff (!rst_ni)
      $onehot0({hit_o, miss_o, prot_o, multi_hit_o}));

endmodule

// File: tlb_l2_search_ctrl.sv
//////////////////////////////////////////////////
// Request capture and busy flag
// Search FSM with offset counter
//////////////////////////////////////////////////

`include "tlb_l2_consts.svh"

module tlb_l2_search_ctrl (
   input  logic                          clk_i,
   input  logic                          rst_ni,
   input  logic                          req_i,
   input  tlb_l2_pkg::va_addr_t          req_addr_i,
   input  tlb_l2_pkg::access_e           req_acc_i,
   input  logic                          cfg_we_i,
   input  logic                          found_i,
   input  logic                          result_done_i,
   input  logic                          trans_sent_i,
   output logic                          busy_o,
   output logic                          lookup_o,
   output tlb_l2_pkg::set_idx_t          set_o,
   output tlb_l2_pkg::offset_idx_t       offset_o,
   output tlb_l2_pkg::vpn_t              vpn_o,
   output tlb_l2_pkg::access_e           acc_o,
   output logic                          last_o,
   output logic [`TLB_PAGE_BITS-1:0]     page_offset_o
);

   import tlb_l2_pkg::*;

   search_state_e               state_q, state_d;
   offset_idx_t                 offset_q;
   logic                        issued_all_q;   // Offset 3 already looked up
   logic                        last_cmp_q;     // Offset 3 compared this cycle
   logic                        accept;
   vpn_t                        vpn_q;
   access_e                     acc_q;
   logic [`TLB_PAGE_BITS-1:0]   page_offset_q;

   assign busy_o = (state_q != S_IDLE);
   assign accept = req_i && !busy_o;

   //////////////////////////////////////////////////
   // Search FSM
   //////////////////////////////////////////////////

   always_comb begin
      state_d = state_q;
      unique case (state_q)
         S_IDLE:   if (accept) state_d = S_START;
         S_START:  state_d = S_SEARCH;
         S_SEARCH: if (found_i || last_cmp_q) state_d = S_DONE;
         S_DONE:   if (trans_sent_i || result_done_i) state_d = S_IDLE;
         default:  state_d = S_IDLE;
      endcase
   end

   // Any configuration write stalls the lookup
   assign lookup_o = (state_q == S_SEARCH) && !cfg_we_i && !issued_all_q;
   assign last_o   = lookup_o && (offset_q == '1);

   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         state_q      <= S_IDLE;
         offset_q     <= '0;
         issued_all_q <= 1'b0;
         last_cmp_q   <= 1'b0;
      end else begin
         state_q    <= state_d;
         last_cmp_q <= last_o;
         if (state_q == S_START) begin
            offset_q     <= '0;
            issued_all_q <= 1'b0;
         end else if (last_o) begin
            issued_all_q <= 1'b1;
         end else if (lookup_o) begin
            offset_q <= offset_q + 1'b1;
         end
      end
   end

   // Request payload
   always_ff @(posedge clk_i) begin
      if (accept) begin
         vpn_q         <= vpn_t'(req_addr_i >> `TLB_PAGE_BITS);
         acc_q         <= req_acc_i;
         page_offset_q <= req_addr_i[`TLB_PAGE_BITS-1:0];
      end
   end

   assign set_o         = vpn_q[`TLB_SET_BITS-1:0];
   assign offset_o      = offset_q;
   assign vpn_o         = vpn_q;
   assign acc_o         = acc_q;
   assign page_offset_o = page_offset_q;

   a_no_offset_wrap : assert property (@(posedge clk_i) disable iff (!rst_ni)
      (state_q == S_SEARCH) && (offset_q == '1) |=> (offset_q == '1));

endmodule

// File: tlb_l2_va_bank.sv
//////////////////////////////////////////////////
// One virtual-page bank with two RAM halves
// Write decode, page match and permission check
//////////////////////////////////////////////////

`include "tlb_l2_consts.svh"

module tlb_l2_va_bank #(
   parameter int unsigned BANK_ID = 0
) (
   input  logic                                    clk_i,
   input  logic                                    rst_ni,
   input  logic                                    cfg_we_i,
   input  tlb_l2_pkg::cfg_addr_t                   cfg_addr_i,
   input  tlb_l2_pkg::va_word_t                    cfg_wdata_i,
   input  logic                                    lookup_i,
   input  tlb_l2_pkg::set_idx_t                    set_i,
   input  tlb_l2_pkg::offset_idx_t                 offset_i,
   input  tlb_l2_pkg::vpn_t                        vpn_i,
   input  tlb_l2_pkg::access_e                     acc_i,
   output logic                                    match_o,
   output logic                                    dual_match_o,
   output logic                                    perm_fault_o,
   output logic                                    coherent_o,
   output logic [$bits(tlb_l2_pkg::entry_idx_t):0] hit_entry_o
);

   import tlb_l2_pkg::*;

   logic              bank_we;
   logic [1:0]        half_we;
   entry_idx_t        ram_addr;
   entry_idx_t        entry_q;     // Entry of the lookup being compared
   logic              lookup_q;
   va_word_t [1:0]    rdata;
   logic [1:0]        half_match;
   logic              hit_half;
   va_word_t          hit_word;
   logic              perm_ok;

   //////////////////////////////////////////////////
   // Write decode and RAM halves
   //////////////////////////////////////////////////

   assign bank_we = cfg_we_i && !cfg_addr_i[`TLB_CFG_PA_SEL_BIT] &&
                    (cfg_addr_i[`TLB_BANK_BITS-1:0] == bank_idx_t'(BANK_ID));

   assign half_we[0] = bank_we && !cfg_addr_i[`TLB_CFG_HALF_BIT];
   assign half_we[1] = bank_we &&  cfg_addr_i[`TLB_CFG_HALF_BIT];

   // Configuration write takes the port
   assign ram_addr = bank_we ? cfg_addr_i[`TLB_CFG_PA_SEL_BIT-1:`TLB_CFG_OFFSET_LSB]
                             : {set_i, offset_i};

   for (genvar h = 0; h < 2; h++) begin : g_half
      tlb_l2_ram #(
         .ADDR_WIDTH ($bits(entry_idx_t)),
         .DATA_WIDTH (`TLB_VA_DATA_WIDTH)
      ) u_ram (
         .clk_i   (clk_i),
         .we_i    (half_we[h]),
         .addr_i  (ram_addr),
         .wdata_i (cfg_wdata_i),
         .rdata_o (rdata[h])
      );

      assign half_match[h] = rdata[h][`TLB_VA_VALID_BIT] && (vpn_t'(rdata[h]) == vpn_i);
   end

   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         lookup_q <= 1'b0;
      end else begin
         lookup_q <= lookup_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (lookup_i) begin
         entry_q <= ram_addr;
      end
   end

   //////////////////////////////////////////////////
   // Compare
   //////////////////////////////////////////////////

   assign hit_half = half_match[1];
   assign hit_word = rdata[hit_half];
   assign perm_ok  = (acc_i == ACC_WRITE) ? hit_word[`TLB_VA_WR_BIT] : hit_word[`TLB_VA_RD_BIT];

   assign match_o      = lookup_q && |half_match;
   assign dual_match_o = lookup_q && &half_match;
   assign perm_fault_o = match_o && !perm_ok;
   assign coherent_o   = hit_word[`TLB_VA_COH_BIT];
   assign hit_entry_o  = {entry_q, hit_half};

   // The search pauses while this bank takes a write
   a_no_lookup_on_write : assert property (@(posedge clk_i) disable iff (!rst_ni)
      !(bank_we && lookup_i));

endmodule
